//--- src/pipe_macros.svh
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// integer datapath width
`define XLEN 64

// byte address bits decoded by the data RAM (1 KiB)
`define DRAM_ADDR_BITS 10

// architectural register count, x0 included
`define NUM_REGS 32

// instruction word width
`define INST_BITS 32

// register index width
`define REG_IDX_BITS 5

`endif

//--- src/pipe_pkg.sv
`include "pipe_macros.svh"

package pipe_pkg;

    typedef logic [`XLEN-1:0]         xlen_t;    // data or address word
    typedef logic [`INST_BITS-1:0]    inst_t;
    typedef logic [`REG_IDX_BITS-1:0] reg_idx_t;

    // load func3, stores use bits [1:0] only
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } mem_func3_e;

    // source of the register write value
    typedef enum logic [1:0] {
        SEL_ALU  = 2'd0,
        SEL_LOAD = 2'd1,
        SEL_PC4  = 2'd2
    } wreg_sel_e;

    typedef struct packed {
        inst_t      inst;
        xlen_t      pc;
        xlen_t      alu_result;    // memory address for loads and stores
        xlen_t      src2;          // store data
        logic       mem_ren;
        logic       mem_wen;
        mem_func3_e func3;
        wreg_sel_e  wreg_sel;
        logic       reg_wen;
        reg_idx_t   rd;
    } ex_to_mem_t;

    typedef struct packed {
        inst_t     inst;
        xlen_t     pc;
        logic      reg_wen;
        reg_idx_t  rd;
        wreg_sel_e wreg_sel;
        xlen_t     rdata;          // extended load value
        xlen_t     alu_result;
    } mem_to_wb_t;

    typedef struct packed {
        logic     wen;
        reg_idx_t rd;
        xlen_t    wdata;
    } reg_wr_t;

    // one retired instruction
    typedef struct packed {
        xlen_t   pc;
        inst_t   inst;
        reg_wr_t reg_wr;
    } commit_t;

endpackage

//--- src/data_ram.sv
`timescale 1ns/100ps
`include "pipe_macros.svh"

module data_ram (
    input  logic                 clk,
    input  logic                 mem_ren,
    input  logic                 mem_wen,
    input  pipe_pkg::mem_func3_e func3,
    input  pipe_pkg::xlen_t      addr,
    input  pipe_pkg::xlen_t      wdata,
    output pipe_pkg::xlen_t      rdata
);
    import pipe_pkg::*;

    localparam int unsigned AW        = `DRAM_ADDR_BITS;
    localparam int unsigned RAM_BYTES = 1 << AW;

    typedef logic [AW-1:0] ram_addr_t;

    logic [7:0] mem [RAM_BYTES];    // little-endian byte storage

    logic [1:0] size;               // log2 of access bytes
    ram_addr_t  byte_addr;
    ram_addr_t  base;               // address aligned down to size
    logic [7:0] byte_en;
    xlen_t      raw;                // eight bytes from base upward
    xlen_t      load_val;

    assign size      = func3[1:0];
    assign byte_addr = addr[AW-1:0];    // upper bits ignored

    always_comb begin
        case (size)
            2'd0:    base = byte_addr;
            2'd1:    base = {byte_addr[AW-1:1], 1'b0};
            2'd2:    base = {byte_addr[AW-1:2], 2'b0};
            default: base = {byte_addr[AW-1:3], 3'b0};
        endcase
    end

    always_comb begin
        case (size)
            2'd0:    byte_en = 8'h01;
            2'd1:    byte_en = 8'h03;
            2'd2:    byte_en = 8'h0f;
            default: byte_en = 8'hff;
        endcase
    end

    // gather a full doubleword, sizing happens below
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            raw[i*8 +: 8] = mem[base + ram_addr_t'(i)];    // wraps at top of RAM
        end
    end

    always_comb begin
        case (func3)
            LB:      load_val = {{(`XLEN-8){raw[7]}}, raw[7:0]};
            LH:      load_val = {{(`XLEN-16){raw[15]}}, raw[15:0]};
            LW:      load_val = {{(`XLEN-32){raw[31]}}, raw[31:0]};
            LD:      load_val = raw;
            LBU:     load_val = {{(`XLEN-8){1'b0}}, raw[7:0]};
            LHU:     load_val = {{(`XLEN-16){1'b0}}, raw[15:0]};
            LWU:     load_val = {{(`XLEN-32){1'b0}}, raw[31:0]};
            default: load_val = '0;    // 3'b111 is not a load
        endcase
    end

    assign rdata = mem_ren ? load_val : '0;

    // store low bytes of wdata into the enabled lanes
    always_ff @(posedge clk) begin
        if (mem_wen) begin
            for (int i = 0; i < 8; i++) begin
                if (byte_en[i]) begin
                    mem[base + ram_addr_t'(i)] <= wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

//--- src/mem_stage.sv
`timescale 1ns/100ps

module mem_stage (
    input  logic                 clk,
    input  logic                 rst,
    // allowin chain
    input  logic                 ws_allowin,
    output logic                 ms_allowin,
    // from execute
    input  logic                 es_to_ms_valid,
    input  pipe_pkg::ex_to_mem_t es_to_ms_bus,
    // to writeback
    output logic                 ms_to_ws_valid,
    output pipe_pkg::mem_to_wb_t ms_to_ws_bus
);
    import pipe_pkg::*;

    logic       ms_valid;
    ex_to_mem_t ms_bus;         // held execute bus
    logic       ms_ready_go;
    logic       ram_ren;
    logic       ram_wen;
    xlen_t      ms_rdata;

    assign ms_ready_go    = 1'b1;    // RAM answers in the same cycle
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    // keeps old contents when nothing is taken, ms_valid qualifies them
    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_bus <= es_to_ms_bus;
        end
    end

    // bubbles must not touch memory
    assign ram_ren = ms_valid && ms_bus.mem_ren;
    assign ram_wen = ms_valid && ms_bus.mem_wen;

    data_ram u_data_ram (
        .clk     (clk),
        .mem_ren (ram_ren),
        .mem_wen (ram_wen),
        .func3   (ms_bus.func3),
        .addr    (ms_bus.alu_result),
        .wdata   (ms_bus.src2),
        .rdata   (ms_rdata)
    );

    always_comb begin
        ms_to_ws_bus.inst       = ms_bus.inst;
        ms_to_ws_bus.pc         = ms_bus.pc;         // for pc+4 on jumps
        ms_to_ws_bus.reg_wen    = ms_bus.reg_wen;
        ms_to_ws_bus.rd         = ms_bus.rd;
        ms_to_ws_bus.wreg_sel   = ms_bus.wreg_sel;
        ms_to_ws_bus.rdata      = ms_rdata;
        ms_to_ws_bus.alu_result = ms_bus.alu_result;
    end

endmodule

//--- src/wb_stage.sv
`timescale 1ns/100ps

module wb_stage (
    input  logic                 clk,
    input  logic                 rst,
    // allowin chain
    output logic                 ws_allowin,
    // from memory stage
    input  logic                 ms_to_ws_valid,
    input  pipe_pkg::mem_to_wb_t ms_to_ws_bus,
    // to register file
    output pipe_pkg::reg_wr_t    reg_wr,
    // retirement report
    output logic                 commit_valid,
    output pipe_pkg::commit_t    commit
);
    import pipe_pkg::*;

    logic       ws_valid;
    mem_to_wb_t ws_bus;
    logic       ws_ready_go;
    xlen_t      ws_wdata;

    assign ws_ready_go = 1'b1;    // retire in one cycle
    assign ws_allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus <= ms_to_ws_bus;
        end
    end

    always_comb begin
        case (ws_bus.wreg_sel)
            SEL_LOAD: ws_wdata = ws_bus.rdata;
            SEL_PC4:  ws_wdata = ws_bus.pc + xlen_t'(4);    // link address
            default:  ws_wdata = ws_bus.alu_result;
        endcase
    end

    // x0 writes are dropped here
    assign reg_wr.wen   = ws_valid && ws_bus.reg_wen && (ws_bus.rd != '0);
    assign reg_wr.rd    = ws_bus.rd;
    assign reg_wr.wdata = ws_wdata;

    assign commit_valid = ws_valid && ws_ready_go;

    always_comb begin
        commit.pc     = ws_bus.pc;
        commit.inst   = ws_bus.inst;
        commit.reg_wr = reg_wr;
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/100ps
`include "pipe_macros.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  pipe_pkg::reg_wr_t  reg_wr,
    input  pipe_pkg::reg_idx_t rs1_addr,
    input  pipe_pkg::reg_idx_t rs2_addr,
    output pipe_pkg::xlen_t    rs1_data,
    output pipe_pkg::xlen_t    rs2_data
);
    import pipe_pkg::*;

    xlen_t regs [1:`NUM_REGS-1];    // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr.wen && (reg_wr.rd != '0)) begin
            regs[reg_wr.rd] <= reg_wr.wdata;
        end
    end

    // asynchronous reads, old value during the write cycle
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- src/mem_wb_top.sv
`timescale 1ns/100ps

module mem_wb_top (
    input  logic                 clk,
    input  logic                 rst,
    // execute side
    input  logic                 es_to_ms_valid,
    input  pipe_pkg::ex_to_mem_t es_to_ms_bus,
    output logic                 ms_allowin,
    // retirement
    output logic                 commit_valid,
    output pipe_pkg::commit_t    commit,
    // decode read ports
    input  pipe_pkg::reg_idx_t   rs1_addr,
    input  pipe_pkg::reg_idx_t   rs2_addr,
    output pipe_pkg::xlen_t      rs1_data,
    output pipe_pkg::xlen_t      rs2_data
);
    import pipe_pkg::*;

    logic       ws_allowin;
    logic       ms_to_ws_valid;
    mem_to_wb_t ms_to_ws_bus;
    reg_wr_t    reg_wr;

    mem_stage u_mem_stage (
        .clk            (clk),
        .rst            (rst),
        .ws_allowin     (ws_allowin),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus)
    );

    wb_stage u_wb_stage (
        .clk            (clk),
        .rst            (rst),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .reg_wr         (reg_wr),
        .commit_valid   (commit_valid),
        .commit         (commit)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .reg_wr   (reg_wr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

//--- verif/mem_wb_asserts.sv
`timescale 1ns/100ps

module mem_wb_asserts (
    input logic              clk,
    input logic              rst,
    input logic              ms_allowin,
    input logic              ws_allowin,
    input logic              ms_to_ws_valid,    // ms_valid, ready_go is constant
    input logic              commit_valid,      // ws_valid
    input pipe_pkg::reg_wr_t reg_wr
);

    allowin_chain: assert property (@(posedge clk) disable iff (rst) ws_allowin |-> ms_allowin)
        else $error("ms_allowin low while ws_allowin is high");

    ms_empty_after_reset: assert property (@(posedge clk) rst |=> !ms_to_ws_valid)
        else $error("memory stage holds a valid item right after reset");

    ms_to_ws_flow: assert property (@(posedge clk) disable iff (rst)
        (ms_to_ws_valid && ws_allowin) |=> commit_valid)
        else $error("memory stage item did not reach writeback");

    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        reg_wr.wen |-> (reg_wr.rd != 5'd0))
        else $error("register write enabled for x0");

endmodule

//--- verif/tb_checker.sv
`timescale 1ns/100ps
`include "pipe_macros.svh"

module tb_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 es_to_ms_valid,
    input  pipe_pkg::ex_to_mem_t es_to_ms_bus,
    input  logic                 ms_allowin,
    input  logic                 commit_valid,
    input  pipe_pkg::commit_t    commit,
    input  pipe_pkg::reg_idx_t   rs1_addr,
    input  pipe_pkg::reg_idx_t   rs2_addr,
    input  pipe_pkg::xlen_t      rs1_data,
    input  pipe_pkg::xlen_t      rs2_data,
    output int                   errors,
    output int                   checks,
    output int                   pending
);
    import pipe_pkg::*;

    localparam int RAM_BYTES = 1 << `DRAM_ADDR_BITS;

    typedef logic [`DRAM_ADDR_BITS-1:0] maddr_t;

    typedef struct packed {
        int      due;      // cycle in which the commit is expected
        xlen_t   pc;
        inst_t   inst;
        reg_wr_t wr;
    } expect_t;

    logic [7:0] mem_model [RAM_BYTES];
    xlen_t      reg_model [`NUM_REGS];
    expect_t    expq [$];
    int         cyc;

    function automatic void compare(input string name, input xlen_t got, input xlen_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, want);
        end
    endfunction

    function automatic maddr_t align_down(input xlen_t addr, input logic [1:0] size);
        maddr_t a;
        a = addr[`DRAM_ADDR_BITS-1:0];
        return a & ~((maddr_t'(1) << size) - maddr_t'(1));
    endfunction

    function automatic xlen_t load_value(input mem_func3_e f3, input xlen_t addr);
        maddr_t base;
        xlen_t  val;
        int     nbytes;
        int     shift;
        base   = align_down(addr, f3[1:0]);
        nbytes = 1 << f3[1:0];
        val    = '0;
        for (int i = 0; i < nbytes; i++) begin
            val[i*8 +: 8] = mem_model[base + maddr_t'(i)];    // little-endian
        end
        shift = 64 - 8 * nbytes;
        if (!f3[2]) begin    // signed forms
            val = xlen_t'($signed(val << shift) >>> shift);
        end
        return val;
    endfunction

    function automatic void store_bytes(input mem_func3_e f3, input xlen_t addr, input xlen_t data);
        maddr_t base;
        int     nbytes;
        base   = align_down(addr, f3[1:0]);
        nbytes = 1 << f3[1:0];
        for (int i = 0; i < nbytes; i++) begin
            mem_model[base + maddr_t'(i)] = data[i*8 +: 8];
        end
    endfunction

    // memory effects applied in acceptance order
    function automatic expect_t predict(input ex_to_mem_t b);
        expect_t e;
        xlen_t   ld;
        ld = b.mem_ren ? load_value(b.func3, b.alu_result) : '0;
        if (b.mem_wen) begin
            store_bytes(b.func3, b.alu_result, b.src2);
        end
        e.due    = 0;
        e.pc     = b.pc;
        e.inst   = b.inst;
        e.wr.wen = b.reg_wen && (b.rd != 5'd0);
        e.wr.rd  = b.rd;
        case (b.wreg_sel)
            SEL_LOAD: e.wr.wdata = ld;
            SEL_PC4:  e.wr.wdata = b.pc + 64'd4;
            default:  e.wr.wdata = b.alu_result;
        endcase
        return e;
    endfunction

    always @(negedge clk) begin
        expect_t e;
        if (rst) begin
            cyc = 0;
            expq.delete();
            for (int i = 0; i < `NUM_REGS; i++) begin
                reg_model[i] = '0;
            end
        end else begin
            cyc = cyc + 1;
            compare("ms_allowin", 64'(ms_allowin), 64'd1);
            compare("rs1_data", rs1_data, reg_model[rs1_addr]);    // pre-write values
            compare("rs2_data", rs2_data, reg_model[rs2_addr]);
            if (expq.size() > 0 && expq[0].due == cyc) begin
                e = expq.pop_front();
                if (!commit_valid) begin
                    errors++;
                    $display("tb_checker: commit of pc %h did not appear in cycle %0d", e.pc, cyc);
                end else begin
                    compare("commit.pc", commit.pc, e.pc);
                    compare("commit.inst", 64'(commit.inst), 64'(e.inst));
                    compare("commit.reg_wr.wen", 64'(commit.reg_wr.wen), 64'(e.wr.wen));
                    compare("commit.reg_wr.rd", 64'(commit.reg_wr.rd), 64'(e.wr.rd));
                    compare("commit.reg_wr.wdata", commit.reg_wr.wdata, e.wr.wdata);
                end
                if (e.wr.wen) begin
                    reg_model[e.wr.rd] = e.wr.wdata;    // seen from the next cycle
                end
            end else if (commit_valid) begin
                errors++;
                $display("tb_checker: commit of pc %h in cycle %0d was not expected", commit.pc, cyc);
            end
            if (es_to_ms_valid && ms_allowin) begin    // taken at the coming edge
                e     = predict(es_to_ms_bus);
                e.due = cyc + 2;
                expq.push_back(e);
            end
        end
        pending = expq.size();
    end

endmodule

//--- verif/tb_top.sv
`timescale 1ns/100ps
`include "pipe_macros.svh"

module tb_top;
    import pipe_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;

    typedef enum logic [1:0] {
        K_ALU,
        K_LOAD,
        K_STORE,
        K_JUMP
    } kind_e;

    typedef struct packed {
        kind_e      kind;
        mem_func3_e func3;
        xlen_t      addr;       // used by loads and stores only
        reg_idx_t   rd;
        logic       reg_wen;
        int         idle;       // empty cycles before the row
    } row_t;

    logic        clk;
    logic        rst;
    logic        es_to_ms_valid;
    ex_to_mem_t  es_to_ms_bus;
    logic        ms_allowin;
    logic        commit_valid;
    commit_t     commit;
    reg_idx_t    rs1_addr;
    reg_idx_t    rs2_addr;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    int          errors;
    int          checks;
    int          pending;
    logic [31:0] lfsr;
    xlen_t       next_pc;
    logic        table_ready;
    row_t        rows [$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);    // one step per bit
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic add_row(input kind_e kind, input mem_func3_e func3, input xlen_t addr,
                           input reg_idx_t rd, input logic reg_wen, input int idle);
        row_t r;
        r.kind    = kind;
        r.func3   = func3;
        r.addr    = addr;
        r.rd      = rd;
        r.reg_wen = reg_wen;
        r.idle    = idle;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(K_STORE, LD,  64'h000, 5'd0,  1'b0, 0);    // seed the doublewords
        add_row(K_STORE, LD,  64'h008, 5'd0,  1'b0, 0);
        add_row(K_STORE, LD,  64'h010, 5'd0,  1'b0, 0);
        add_row(K_STORE, LD,  64'h018, 5'd0,  1'b0, 1);
        add_row(K_STORE, LD,  64'hffff_0000_0000_0100, 5'd0, 1'b0, 0);    // upper bits ignored
        add_row(K_LOAD,  LD,  64'h000, 5'd1,  1'b1, 0);
        add_row(K_LOAD,  LW,  64'h006, 5'd2,  1'b1, 0);    // aligns down to 0x004
        add_row(K_LOAD,  LWU, 64'h00c, 5'd3,  1'b1, 2);
        add_row(K_LOAD,  LH,  64'h013, 5'd4,  1'b1, 0);
        add_row(K_LOAD,  LHU, 64'h016, 5'd5,  1'b1, 0);
        add_row(K_LOAD,  LB,  64'h019, 5'd6,  1'b1, 3);
        add_row(K_LOAD,  LBU, 64'h01f, 5'd7,  1'b1, 0);
        add_row(K_STORE, LB,  64'h003, 5'd0,  1'b0, 0);
        add_row(K_LOAD,  LD,  64'h000, 5'd8,  1'b1, 0);    // right behind the byte store
        add_row(K_STORE, LH,  64'h00b, 5'd0,  1'b0, 1);
        add_row(K_LOAD,  LH,  64'h00a, 5'd9,  1'b1, 0);
        add_row(K_LOAD,  LD,  64'h008, 5'd10, 1'b1, 0);
        add_row(K_STORE, LW,  64'h016, 5'd0,  1'b0, 0);
        add_row(K_LOAD,  LBU, 64'h017, 5'd11, 1'b1, 0);
        add_row(K_LOAD,  LD,  64'h010, 5'd12, 1'b1, 2);
        add_row(K_ALU,   LB,  64'h000, 5'd13, 1'b1, 0);
        add_row(K_ALU,   LB,  64'h000, 5'd0,  1'b1, 0);    // x0 write attempt
        add_row(K_ALU,   LB,  64'h000, 5'd14, 1'b0, 1);
        add_row(K_JUMP,  LB,  64'h000, 5'd1,  1'b1, 0);    // overwrites x1 with the link
        add_row(K_JUMP,  LB,  64'h000, 5'd0,  1'b1, 3);
        add_row(K_LOAD,  LD,  64'h100, 5'd0,  1'b1, 0);
        add_row(K_LOAD,  LW,  64'h7fff_0000_0000_0104, 5'd15, 1'b1, 0);
        add_row(K_ALU,   LB,  64'h000, 5'd31, 1'b1, 0);
    endtask

    task automatic send_row(input row_t r);
        ex_to_mem_t b;
        b.inst = 32'(take_bits(32));
        b.pc   = next_pc;
        b.src2 = take_bits(64);
        if (r.kind == K_LOAD || r.kind == K_STORE) begin
            b.alu_result = r.addr;
        end else begin
            b.alu_result = take_bits(64);
        end
        b.mem_ren = (r.kind == K_LOAD);
        b.mem_wen = (r.kind == K_STORE);
        b.func3   = r.func3;
        case (r.kind)
            K_LOAD:  b.wreg_sel = SEL_LOAD;
            K_JUMP:  b.wreg_sel = SEL_PC4;
            default: b.wreg_sel = SEL_ALU;
        endcase
        b.reg_wen = r.reg_wen;
        b.rd      = r.rd;
        next_pc   = next_pc + 64'd4;
        repeat (r.idle) begin
            @(posedge clk);
            es_to_ms_valid <= 1'b0;
        end
        @(posedge clk);
        es_to_ms_valid <= 1'b1;
        es_to_ms_bus   <= b;
        @(negedge clk);
        while (!ms_allowin) begin    // taken at the next rising edge
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        rs1_addr <= rs1_addr + 5'd1;
        rs2_addr <= rs2_addr + 5'd7;    // odd step reaches every index
    end

    mem_wb_top UUT (
        .clk            (clk),
        .rst            (rst),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data)
    );

    tb_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .errors         (errors),
        .checks         (checks),
        .pending        (pending)
    );

    // handshake and x0 rules across both stages
    bind mem_wb_top mem_wb_asserts u_asserts (
        .clk            (clk),
        .rst            (rst),
        .ms_allowin     (ms_allowin),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .commit_valid   (commit_valid),
        .reg_wr         (reg_wr)
    );

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        es_to_ms_valid = 1'b0;
        es_to_ms_bus   = '0;
        rs1_addr       = '0;
        rs2_addr       = '0;
        lfsr           = 32'h22d77ccd;
        next_pc        = 64'h1000;
        table_ready    = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        foreach (rows[i]) begin
            send_row(rows[i]);
        end
        @(posedge clk);
        es_to_ms_valid <= 1'b0;
        wait (pending == 0);
        repeat (`NUM_REGS + 2) @(posedge clk);    // rs1 sweep passes every register
        $display("tb_top: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        int max_idle;
        wait (table_ready);
        max_idle = 0;
        foreach (rows[i]) begin
            if (rows[i].idle > max_idle) begin
                max_idle = rows[i].idle;
            end
        end
        limit = (rows.size() * (max_idle + 4) + RESET_CYCLES) * CLK_PERIOD;
        #(limit);
        $display("tb_top: timeout after %0d ns, the pipeline stopped draining", limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- files.f
+incdir+src
src/pipe_pkg.sv
src/data_ram.sv
src/mem_stage.sv
src/wb_stage.sv
src/reg_file.sv
src/mem_wb_top.sv
verif/mem_wb_asserts.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f files.f -Mdir obj_dir -o sim

# exit status of the simulator is not used, the log decides
./obj_dir/sim | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "run.sh: simulation passed"
    exit 0
fi
echo "run.sh: simulation did not pass, see sim.log"
exit 1
